// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_axi_read
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Something failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/icache_if_pkg.sv
// ******************************
// I$ side types, tid carries the memory ID
// ******************************
`include "mem_bus_params.svh"

package icache_if_pkg;

  // Miss request as issued by the instruction cache
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] paddr;
    // Non-cacheable fetch, single beat
    logic                   nc;
    logic [`MEM_ID_W-1:0]   tid;
  } icache_miss_req_t;

  // Refill return, one full line
  typedef struct packed {
    logic [`MEM_ID_W-1:0]      tid;
    logic [`ICACHE_LINE_W-1:0] line;
  } icache_refill_t;

endpackage

// File: common/mem_bus_params.svh
// ******************************
// Bus fixed narrower than the I$ line
// Line width must be a multiple of the beat width
// ******************************
`ifndef MEM_BUS_PARAMS_SVH
`define MEM_BUS_PARAMS_SVH

// Physical address width
`define MEM_ADDR_W 32

// One memory/AXI beat
`define MEM_DATA_W 64

// Transaction ID width, shared by AR and R
`define MEM_ID_W 4

// Instruction cache line
`define ICACHE_LINE_W 128

// Beats per I$ line
`define ICACHE_BEATS 2

// AXI size code of one 64-bit beat
`define MEM_BEAT_SIZE 3

`endif

// File: common/mem_rd_pkg.sv
// ******************************
// Read-only memory and AXI channel types
// ******************************
`include "mem_bus_params.svh"

package mem_rd_pkg;

  // Requester slots on the read arbiter and response demux
  localparam int unsigned N_PORTS       = 3;
  localparam int unsigned PORT_ICACHE   = 0;
  localparam int unsigned PORT_DCACHE   = 1;
  localparam int unsigned PORT_UNCACHED = 2;

  // AXI encodings used on AR
  localparam logic [1:0] AXI_BURST_INCR      = 2'b01;
  localparam logic [3:0] AXI_CACHE_WB_ALLOC  = 4'b1111;
  localparam logic [3:0] AXI_CACHE_DEVICE_NB = 4'b0000;

  // Request into the arbiter, len is beats minus one
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [`MEM_ID_W-1:0]   id;
    logic                   cacheable;
  } mem_rd_req_t;

  // One returned beat
  typedef struct packed {
    logic [`MEM_ID_W-1:0]   id;
    logic [`MEM_DATA_W-1:0] data;
    logic                   last;
  } mem_rd_resp_t;

  typedef struct packed {
    logic [`MEM_ID_W-1:0]   id;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
    logic [3:0]             cache;
  } axi_ar_t;

  typedef struct packed {
    logic [`MEM_ID_W-1:0]   id;
    logic [`MEM_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } axi_r_t;

endpackage

// File: project.f
+incdir+common
common/icache_if_pkg.sv
common/mem_rd_pkg.sv
rtl/icache_refill/icache_miss_adapter.sv
rtl/mem_read_arbiter.sv
rtl/mem_resp_read_demux.sv
rtl/mem_to_axi_read.sv
rtl/cache_axi_read_arbiter.sv
test/tb_axi_read_sva.sv
test/tb_cache_axi_read.sv

// File: rtl/cache_axi_read_arbiter.sv
// ******************************
// Read side only, no AW/W/B channels
// ******************************
`timescale 1ns/1ps
`include "mem_bus_params.svh"

module cache_axi_read_arbiter (
  input  logic                            clk_i,
  input  logic                            reset_i,

  // Instruction cache
  input  logic                            icache_miss_valid_i,
  input  icache_if_pkg::icache_miss_req_t icache_miss_i,
  output logic                            icache_miss_ready_o,
  output logic                            icache_refill_valid_o,
  output icache_if_pkg::icache_refill_t   icache_refill_o,
  input  logic [`MEM_ID_W-1:0]            icache_id_i,

  // Data cache refills
  input  logic                            dcache_miss_valid_i,
  input  mem_rd_pkg::mem_rd_req_t         dcache_miss_i,
  output logic                            dcache_miss_ready_o,
  output logic                            dcache_miss_resp_valid_o,
  output mem_rd_pkg::mem_rd_resp_t        dcache_miss_resp_o,
  input  logic                            dcache_miss_resp_ready_i,

  // Data cache uncached reads
  input  logic                            uc_read_valid_i,
  input  mem_rd_pkg::mem_rd_req_t         uc_read_i,
  output logic                            uc_read_ready_o,
  input  logic [`MEM_ID_W-1:0]            uc_read_id_i,
  output logic                            uc_read_resp_valid_o,
  output mem_rd_pkg::mem_rd_resp_t        uc_read_resp_o,
  input  logic                            uc_read_resp_ready_i,

  // AXI read port
  output logic                            ar_valid_o,
  output mem_rd_pkg::axi_ar_t             ar_o,
  input  logic                            ar_ready_i,
  input  logic                            r_valid_i,
  input  mem_rd_pkg::axi_r_t              r_i,
  output logic                            r_ready_o
);

  import mem_rd_pkg::*;

  logic                      rd_valid [N_PORTS];
  logic [N_PORTS-1:0]        req_valid;
  logic [N_PORTS-1:0]        req_ready;
  mem_rd_req_t [N_PORTS-1:0] req;
  logic                      arb_valid;
  logic                      arb_ready;
  mem_rd_req_t               arb_req;
  logic                      resp_valid;
  logic                      resp_ready;
  mem_rd_resp_t              resp;
  logic [N_PORTS-1:0]        out_valid;
  logic [N_PORTS-1:0]        out_ready;
  mem_rd_resp_t              out_resp;

  icache_miss_adapter icache_miss_adapter_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_valid_i    (icache_miss_valid_i),
    .miss_i          (icache_miss_i),
    .miss_ready_o    (icache_miss_ready_o),
    .mem_req_valid_o (rd_valid[PORT_ICACHE]),
    .mem_req_o       (req[PORT_ICACHE]),
    .mem_req_ready_i (req_ready[PORT_ICACHE]),
    .resp_valid_i    (out_valid[PORT_ICACHE]),
    .resp_i          (out_resp),
    .resp_ready_o    (out_ready[PORT_ICACHE]),
    .refill_valid_o  (icache_refill_valid_o),
    .refill_o        (icache_refill_o)
  );

  // Data cache ports feed the arbiter directly
  assign rd_valid[PORT_DCACHE]   = dcache_miss_valid_i;
  assign rd_valid[PORT_UNCACHED] = uc_read_valid_i;
  assign req[PORT_DCACHE]        = dcache_miss_i;
  assign req[PORT_UNCACHED]      = uc_read_i;
  assign dcache_miss_ready_o     = req_ready[PORT_DCACHE];
  assign uc_read_ready_o         = req_ready[PORT_UNCACHED];

  always_comb begin
    for (int i = 0; i < N_PORTS; i++) begin
      req_valid[i] = rd_valid[i];
    end
  end

  mem_read_arbiter mem_read_arbiter_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .arb_valid_o (arb_valid),
    .arb_o       (arb_req),
    .arb_ready_i (arb_ready)
  );

  mem_to_axi_read mem_to_axi_read_inst (
    .req_valid_i  (arb_valid),
    .req_i        (arb_req),
    .req_ready_o  (arb_ready),
    .ar_valid_o   (ar_valid_o),
    .ar_o         (ar_o),
    .ar_ready_i   (ar_ready_i),
    .r_valid_i    (r_valid_i),
    .r_i          (r_i),
    .r_ready_o    (r_ready_o),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .resp_ready_i (resp_ready)
  );

  mem_resp_read_demux mem_resp_read_demux_inst (
    .resp_valid_i (resp_valid),
    .resp_i       (resp),
    .resp_ready_o (resp_ready),
    .icache_id_i  (icache_id_i),
    .uc_read_id_i (uc_read_id_i),
    .out_valid_o  (out_valid),
    .out_o        (out_resp),
    .out_ready_i  (out_ready)
  );

  assign dcache_miss_resp_valid_o = out_valid[PORT_DCACHE];
  assign dcache_miss_resp_o       = out_resp;
  assign out_ready[PORT_DCACHE]   = dcache_miss_resp_ready_i;

  assign uc_read_resp_valid_o     = out_valid[PORT_UNCACHED];
  assign uc_read_resp_o           = out_resp;
  assign out_ready[PORT_UNCACHED] = uc_read_resp_ready_i;

endmodule

// File: rtl/icache_refill/icache_miss_adapter.sv
// ******************************
// One request in flight per buffer slot
// Refill has no ready, the I$ must take it
// ******************************
`timescale 1ns/1ps
`include "mem_bus_params.svh"

module icache_miss_adapter (
  input  logic                            clk_i,
  input  logic                            reset_i,

  // Miss requests from the I$
  input  logic                            miss_valid_i,
  input  icache_if_pkg::icache_miss_req_t miss_i,
  output logic                            miss_ready_o,

  // Toward the read arbiter
  output logic                            mem_req_valid_o,
  output mem_rd_pkg::mem_rd_req_t         mem_req_o,
  input  logic                            mem_req_ready_i,

  // Beats routed back by the demux
  input  logic                            resp_valid_i,
  input  mem_rd_pkg::mem_rd_resp_t        resp_i,
  output logic                            resp_ready_o,

  // Assembled line to the I$
  output logic                            refill_valid_o,
  output icache_if_pkg::icache_refill_t   refill_o
);

  import icache_if_pkg::*;
  import mem_rd_pkg::*;

  localparam int unsigned CNT_W = $clog2(`ICACHE_BEATS);

  mem_rd_req_t    req_fmt;
  mem_rd_req_t    buf_q;
  logic           buf_valid_q;
  logic           beat_acc;
  logic [CNT_W-1:0] beat_cnt_q;
  logic           refill_valid_q;
  icache_refill_t refill_q;

  // Miss in memory request format
  always_comb begin
    req_fmt.addr      = miss_i.paddr;
    req_fmt.len       = miss_i.nc ? 8'd0 : 8'(`ICACHE_BEATS - 1);
    req_fmt.size      = 3'(`MEM_BEAT_SIZE);
    req_fmt.id        = miss_i.tid;
    req_fmt.cacheable = ~miss_i.nc;
  end

  // The I$ may withdraw valid, so a miss is captured before it meets the arbiter
  assign miss_ready_o    = ~buf_valid_q;
  assign mem_req_valid_o = buf_valid_q;
  assign mem_req_o       = buf_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_valid_q <= 1'b0;
    end else if (miss_valid_i && miss_ready_o) begin
      buf_valid_q <= 1'b1;
    end else if (mem_req_ready_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_valid_i && miss_ready_o) begin
      buf_q <= req_fmt;
    end
  end

  // Upsizer never stalls, a new beat lands after the line was shown
  assign resp_ready_o = 1'b1;
  assign beat_acc     = resp_valid_i & resp_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_cnt_q     <= '0;
      refill_valid_q <= 1'b0;
    end else begin
      refill_valid_q <= beat_acc & resp_i.last;
      if (beat_acc) begin
        beat_cnt_q <= resp_i.last ? '0 : beat_cnt_q + 1'b1;
      end
    end
  end

  // Line fills from the low end
  always_ff @(posedge clk_i) begin
    if (beat_acc) begin
      if (beat_cnt_q == '0) begin
        // First beat clears the rest of the line
        refill_q.line <= `ICACHE_LINE_W'(resp_i.data);
      end else begin
        refill_q.line[beat_cnt_q*`MEM_DATA_W +: `MEM_DATA_W] <= resp_i.data;
      end
      if (resp_i.last) begin
        refill_q.tid <= resp_i.id;
      end
    end
  end

  assign refill_valid_o = refill_valid_q;
  assign refill_o       = refill_q;

endmodule

// File: rtl/mem_read_arbiter.sv
// ******************************
// Requesters must hold valid until ready
// ******************************
`timescale 1ns/1ps

module mem_read_arbiter (
  input  logic                                         clk_i,
  input  logic                                         reset_i,

  input  logic [mem_rd_pkg::N_PORTS-1:0]                req_valid_i,
  input  mem_rd_pkg::mem_rd_req_t [mem_rd_pkg::N_PORTS-1:0] req_i,
  output logic [mem_rd_pkg::N_PORTS-1:0]                req_ready_o,

  output logic                                         arb_valid_o,
  output mem_rd_pkg::mem_rd_req_t                      arb_o,
  input  logic                                         arb_ready_i
);

  import mem_rd_pkg::*;

  logic [1:0] last_q;
  logic [1:0] hold_idx_q;
  logic       hold_q;
  logic [1:0] rr_pick;
  logic [1:0] gnt_idx;

  // Slot that follows base by step positions
  function automatic logic [1:0] rr_next(input logic [1:0] base, input int step);
    int sum;
    sum = (int'(base) + step) % int'(N_PORTS);
    return sum[1:0];
  endfunction

  // Nearest valid slot after the last one served wins
  always_comb begin
    rr_pick = last_q;
    for (int k = N_PORTS; k >= 1; k--) begin
      if (req_valid_i[rr_next(last_q, k)]) begin
        rr_pick = rr_next(last_q, k);
      end
    end
  end

  assign gnt_idx     = hold_q ? hold_idx_q : rr_pick;
  assign arb_valid_o = req_valid_i[gnt_idx];
  assign arb_o       = req_i[gnt_idx];

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[gnt_idx] = arb_ready_i;
  end

  // Stalled grant stays put so AR remains stable
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q     <= 2'(N_PORTS - 1);
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else if (arb_valid_o && arb_ready_i) begin
      last_q <= gnt_idx;
      hold_q <= 1'b0;
    end else begin
      hold_q     <= arb_valid_o;
      hold_idx_q <= gnt_idx;
    end
  end

endmodule

// File: rtl/mem_resp_read_demux.sv
// ******************************
// I$ ID wins if both IDs are equal
// ******************************
`timescale 1ns/1ps
`include "mem_bus_params.svh"

module mem_resp_read_demux (
  input  logic                                   resp_valid_i,
  input  mem_rd_pkg::mem_rd_resp_t               resp_i,
  output logic                                   resp_ready_o,

  input  logic [`MEM_ID_W-1:0]                   icache_id_i,
  input  logic [`MEM_ID_W-1:0]                   uc_read_id_i,

  output logic [mem_rd_pkg::N_PORTS-1:0]         out_valid_o,
  output mem_rd_pkg::mem_rd_resp_t               out_o,
  input  logic [mem_rd_pkg::N_PORTS-1:0]         out_ready_i
);

  import mem_rd_pkg::*;

  logic [1:0] route;

  // Everything not claimed by I$ or uncached is a D$ refill
  always_comb begin
    if (resp_i.id == icache_id_i) begin
      route = 2'(PORT_ICACHE);
    end else if (resp_i.id == uc_read_id_i) begin
      route = 2'(PORT_UNCACHED);
    end else begin
      route = 2'(PORT_DCACHE);
    end
  end

  always_comb begin
    out_valid_o        = '0;
    out_valid_o[route] = resp_valid_i;
  end

  // Beat waits on R until its target is ready
  assign resp_ready_o = out_ready_i[route];

  // Payload is shared, only the valid is steered
  assign out_o = resp_i;

endmodule

// File: rtl/mem_to_axi_read.sv
// ******************************
// INCR bursts only, R resp code is dropped
// ******************************
`timescale 1ns/1ps

module mem_to_axi_read (
  input  logic                     req_valid_i,
  input  mem_rd_pkg::mem_rd_req_t  req_i,
  output logic                     req_ready_o,

  output logic                     ar_valid_o,
  output mem_rd_pkg::axi_ar_t      ar_o,
  input  logic                     ar_ready_i,

  input  logic                     r_valid_i,
  input  mem_rd_pkg::axi_r_t       r_i,
  output logic                     r_ready_o,

  output logic                     resp_valid_o,
  output mem_rd_pkg::mem_rd_resp_t resp_o,
  input  logic                     resp_ready_i
);

  import mem_rd_pkg::*;

  // AR side
  assign ar_valid_o  = req_valid_i;
  assign req_ready_o = ar_ready_i;

  always_comb begin
    ar_o.id    = req_i.id;
    ar_o.addr  = req_i.addr;
    ar_o.len   = req_i.len;
    ar_o.size  = req_i.size;
    ar_o.burst = AXI_BURST_INCR;
    // Uncached reads go out as device accesses
    ar_o.cache = req_i.cacheable ? AXI_CACHE_WB_ALLOC : AXI_CACHE_DEVICE_NB;
  end

  // R side
  assign resp_valid_o = r_valid_i;
  assign r_ready_o    = resp_ready_i;

  always_comb begin
    resp_o.id   = r_i.id;
    resp_o.data = r_i.data;
    resp_o.last = r_i.last;
  end

endmodule

// File: test/tb_axi_read_sva.sv
// ******************************
// AR stability and idle outputs after reset only
// ******************************
`timescale 1ns/1ps

module tb_axi_read_sva (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                ar_valid_i,
  input  mem_rd_pkg::axi_ar_t ar_i,
  input  logic                ar_ready_i,
  input  logic                refill_valid_i,
  input  logic                miss_resp_valid_i,
  input  logic                uc_resp_valid_i
);

  // A stalled AR keeps valid and payload
  property ar_hold_p;
    @(posedge clk_i) disable iff (reset_i)
      ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i);
  endproperty

  // Outputs come out of reset idle
  property idle_after_reset_p;
    @(posedge clk_i)
      reset_i |=> !(ar_valid_i || refill_valid_i || miss_resp_valid_i || uc_resp_valid_i);
  endproperty

  ar_hold_a: assert property (ar_hold_p)
    else $error("AR changed or dropped while ar_ready_i was low");

  idle_after_reset_a: assert property (idle_after_reset_p)
    else $error("A valid output was high right after reset");

endmodule

// File: test/tb_cache_axi_read.sv
// ******************************
// I$, D$ and uncached IDs must all differ
// ******************************
`timescale 1ns/1ps
`include "mem_bus_params.svh"

module tb_cache_axi_read;

  import icache_if_pkg::*;
  import mem_rd_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          N_TESTS    = 5;
  localparam int          WAIT_LIMIT = 50;
  localparam int          ARB_LIMIT  = 400;
  localparam logic [31:0] SEED       = 32'h18ebb04c;

  localparam logic [`MEM_ID_W-1:0] IC_ID = 4'h1;
  localparam logic [`MEM_ID_W-1:0] DC_ID = 4'h5;
  localparam logic [`MEM_ID_W-1:0] UC_ID = 4'h2;

  // AXI codes expected on AR
  localparam logic [1:0] EXP_BURST  = 2'b01;
  localparam logic [3:0] EXP_CACHED = 4'hf;
  localparam logic [3:0] EXP_DEVICE = 4'h0;

  logic                 clk_i;
  logic                 reset_i;
  logic                 icache_miss_valid_i;
  icache_miss_req_t     icache_miss_i;
  logic                 icache_miss_ready_o;
  logic                 icache_refill_valid_o;
  icache_refill_t       icache_refill_o;
  logic [`MEM_ID_W-1:0] icache_id_i;
  logic                 dcache_miss_valid_i;
  mem_rd_req_t          dcache_miss_i;
  logic                 dcache_miss_ready_o;
  logic                 dcache_miss_resp_valid_o;
  mem_rd_resp_t         dcache_miss_resp_o;
  logic                 dcache_miss_resp_ready_i;
  logic                 uc_read_valid_i;
  mem_rd_req_t          uc_read_i;
  logic                 uc_read_ready_o;
  logic [`MEM_ID_W-1:0] uc_read_id_i;
  logic                 uc_read_resp_valid_o;
  mem_rd_resp_t         uc_read_resp_o;
  logic                 uc_read_resp_ready_i;
  logic                 ar_valid_o;
  axi_ar_t              ar_o;
  logic                 ar_ready_i;
  logic                 r_valid_i;
  axi_r_t               r_i;
  logic                 r_ready_o;
  int                   err_cnt;
  int                   tests_run;

  cache_axi_read_arbiter cache_axi_read_arbiter_inst (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .icache_miss_valid_i      (icache_miss_valid_i),
    .icache_miss_i            (icache_miss_i),
    .icache_miss_ready_o      (icache_miss_ready_o),
    .icache_refill_valid_o    (icache_refill_valid_o),
    .icache_refill_o          (icache_refill_o),
    .icache_id_i              (icache_id_i),
    .dcache_miss_valid_i      (dcache_miss_valid_i),
    .dcache_miss_i            (dcache_miss_i),
    .dcache_miss_ready_o      (dcache_miss_ready_o),
    .dcache_miss_resp_valid_o (dcache_miss_resp_valid_o),
    .dcache_miss_resp_o       (dcache_miss_resp_o),
    .dcache_miss_resp_ready_i (dcache_miss_resp_ready_i),
    .uc_read_valid_i          (uc_read_valid_i),
    .uc_read_i                (uc_read_i),
    .uc_read_ready_o          (uc_read_ready_o),
    .uc_read_id_i             (uc_read_id_i),
    .uc_read_resp_valid_o     (uc_read_resp_valid_o),
    .uc_read_resp_o           (uc_read_resp_o),
    .uc_read_resp_ready_i     (uc_read_resp_ready_i),
    .ar_valid_o               (ar_valid_o),
    .ar_o                     (ar_o),
    .ar_ready_i               (ar_ready_i),
    .r_valid_i                (r_valid_i),
    .r_i                      (r_i),
    .r_ready_o                (r_ready_o)
  );

  bind cache_axi_read_arbiter tb_axi_read_sva axi_read_sva_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .ar_valid_i        (ar_valid_o),
    .ar_i              (ar_o),
    .ar_ready_i        (ar_ready_i),
    .refill_valid_i    (icache_refill_valid_o),
    .miss_resp_valid_i (dcache_miss_resp_valid_o),
    .uc_resp_valid_i   (uc_read_resp_valid_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Run length bounded by 200 cycles per test
  initial begin
    #(N_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles", N_TESTS * 200);
    $display("Something failed");
    $finish;
  end

  task automatic value_error(input string name, input logic [131:0] exp,
                             input logic [131:0] got);
    $display("ERR %s expected %h got %h at %0t", name, exp, got, $time);
    err_cnt++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s at %0t", msg, $time);
    err_cnt++;
  endtask

  function automatic mem_rd_req_t make_read_req(input logic [31:0] addr,
                                                input logic [`MEM_ID_W-1:0] id,
                                                input logic cacheable);
    mem_rd_req_t req;
    req.addr      = addr;
    req.len       = 8'd0;
    req.size      = 3'd3;
    req.id        = id;
    req.cacheable = cacheable;
    return req;
  endfunction

  function automatic int port_of_id(input logic [`MEM_ID_W-1:0] id);
    if (id == IC_ID) return 0;
    if (id == DC_ID) return 1;
    if (id == UC_ID) return 2;
    return 3;
  endfunction

  // I$ holds valid for one transfer, then drops it
  task automatic issue_icache_miss(input logic [31:0] addr, input logic nc);
    int t;
    t = 0;
    @(posedge clk_i);
    icache_miss_valid_i <= 1'b1;
    icache_miss_i       <= {addr, nc, IC_ID};
    @(negedge clk_i);
    while (!icache_miss_ready_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= WAIT_LIMIT) note_failure("I$ miss was never accepted");
    @(posedge clk_i);
    icache_miss_valid_i <= 1'b0;
  endtask

  // ar_ready_i is high here, so the AR is taken on the next edge
  task automatic capture_ar(output axi_ar_t ar);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!ar_valid_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= WAIT_LIMIT) note_failure("No AR request appeared");
    ar = ar_o;
    @(posedge clk_i);
  endtask

  task automatic send_r_beat(input logic [`MEM_ID_W-1:0] id, input logic [63:0] data,
                             input logic last);
    int t;
    t = 0;
    @(posedge clk_i);
    r_valid_i <= 1'b1;
    r_i       <= {id, data, 2'b00, last};
    @(negedge clk_i);
    while (!r_ready_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= WAIT_LIMIT) note_failure("R beat was never accepted");
    @(posedge clk_i);
    r_valid_i <= 1'b0;
  endtask

  task automatic wait_refill(output icache_refill_t rf);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!icache_refill_valid_o && t < WAIT_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (t >= WAIT_LIMIT) note_failure("No I$ refill arrived");
    rf = icache_refill_o;
  endtask

  task automatic check_ar(input axi_ar_t ar, input logic [31:0] addr, input logic [7:0] len,
                          input logic [3:0] cache);
    if (ar.addr !== addr) value_error("ar_o.addr", addr, ar.addr);
    if (ar.id !== IC_ID) value_error("ar_o.id", IC_ID, ar.id);
    if (ar.len !== len) value_error("ar_o.len", len, ar.len);
    if (ar.size !== 3'd3) value_error("ar_o.size", 3'd3, ar.size);
    if (ar.burst !== EXP_BURST) value_error("ar_o.burst", EXP_BURST, ar.burst);
    if (ar.cache !== cache) value_error("ar_o.cache", cache, ar.cache);
  endtask

  task automatic reset_check();
    tests_run++;
    @(negedge clk_i);
    if (ar_valid_o !== 1'b0) value_error("ar_valid_o", 1'b0, ar_valid_o);
    if (icache_refill_valid_o !== 1'b0) begin
      value_error("icache_refill_valid_o", 1'b0, icache_refill_valid_o);
    end
    if (dcache_miss_resp_valid_o !== 1'b0) begin
      value_error("dcache_miss_resp_valid_o", 1'b0, dcache_miss_resp_valid_o);
    end
    if (uc_read_resp_valid_o !== 1'b0) begin
      value_error("uc_read_resp_valid_o", 1'b0, uc_read_resp_valid_o);
    end
    if (icache_miss_ready_o !== 1'b1) value_error("icache_miss_ready_o", 1'b1, icache_miss_ready_o);
  endtask

  // Two beats fill the line low half first
  task automatic icache_cached_check();
    logic [31:0]    addr;
    logic [63:0]    beat0;
    logic [63:0]    beat1;
    axi_ar_t        ar;
    icache_refill_t rf;
    tests_run++;
    addr  = $urandom & 32'hffff_fff0;
    beat0 = {$urandom, $urandom};
    beat1 = {$urandom, $urandom};
    issue_icache_miss(addr, 1'b0);
    capture_ar(ar);
    check_ar(ar, addr, 8'd1, EXP_CACHED);
    send_r_beat(IC_ID, beat0, 1'b0);
    send_r_beat(IC_ID, beat1, 1'b1);
    wait_refill(rf);
    if (rf.tid !== IC_ID) value_error("icache_refill_o.tid", IC_ID, rf.tid);
    if (rf.line !== {beat1, beat0}) value_error("icache_refill_o.line", {beat1, beat0}, rf.line);
  endtask

  task automatic icache_uncached_check();
    logic [31:0]    addr;
    logic [63:0]    beat;
    axi_ar_t        ar;
    icache_refill_t rf;
    tests_run++;
    addr = $urandom & 32'hffff_fff8;
    beat = {$urandom, $urandom};
    issue_icache_miss(addr, 1'b1);
    capture_ar(ar);
    check_ar(ar, addr, 8'd0, EXP_DEVICE);
    send_r_beat(IC_ID, beat, 1'b1);
    wait_refill(rf);
    if (rf.tid !== IC_ID) value_error("icache_refill_o.tid", IC_ID, rf.tid);
    if (rf.line !== {64'h0, beat}) value_error("icache_refill_o.line", {64'h0, beat}, rf.line);
  endtask

  // First pass targets the uncached port, second the refill port
  task automatic routing_check();
    logic [`MEM_ID_W-1:0] id;
    logic [63:0]          data;
    logic                 to_uc;
    int                   stall;
    tests_run++;
    for (int pass = 0; pass < 2; pass++) begin
      to_uc = (pass == 0);
      id    = to_uc ? UC_ID : DC_ID;
      data  = {$urandom, $urandom};
      stall = 2 + int'($urandom % 3);
      @(posedge clk_i);
      r_valid_i <= 1'b1;
      r_i       <= {id, data, 2'b00, 1'b1};
      repeat (stall) begin
        @(negedge clk_i);
        if (r_ready_o !== 1'b0) value_error("r_ready_o", 1'b0, r_ready_o);
        if (uc_read_resp_valid_o !== to_uc) begin
          value_error("uc_read_resp_valid_o", to_uc, uc_read_resp_valid_o);
        end
        if (dcache_miss_resp_valid_o !== !to_uc) begin
          value_error("dcache_miss_resp_valid_o", !to_uc, dcache_miss_resp_valid_o);
        end
      end
      @(posedge clk_i);
      uc_read_resp_ready_i     <= to_uc;
      dcache_miss_resp_ready_i <= !to_uc;
      @(negedge clk_i);
      if (r_ready_o !== 1'b1) value_error("r_ready_o", 1'b1, r_ready_o);
      if (to_uc && uc_read_resp_o !== {id, data, 1'b1}) begin
        value_error("uc_read_resp_o", {id, data, 1'b1}, uc_read_resp_o);
      end
      if (!to_uc && dcache_miss_resp_o !== {id, data, 1'b1}) begin
        value_error("dcache_miss_resp_o", {id, data, 1'b1}, dcache_miss_resp_o);
      end
      @(posedge clk_i);
      r_valid_i                <= 1'b0;
      uc_read_resp_ready_i     <= 1'b0;
      dcache_miss_resp_ready_i <= 1'b0;
    end
  endtask

  // Three requests per requester, all pending at once, random AR stalls
  task automatic arbitration_check();
    logic [35:0]          expect_q[$];
    logic [31:0]          i_q[$];
    logic [31:0]          d_q[$];
    logic [31:0]          u_q[$];
    logic [31:0]          addr;
    logic [`MEM_ID_W-1:0] id;
    logic [2:0]           waiting;
    logic [2:0]           grant_wait;
    logic                 i_buffered;
    logic                 held;
    logic                 i_go;
    logic                 d_go;
    logic                 u_go;
    logic                 d_exp;
    logic                 u_exp;
    axi_ar_t              held_ar;
    int                   last_port;
    int                   port;
    int                   hit;
    int                   cycles;
    tests_run++;
    for (int p = 0; p < 3; p++) begin
      for (int k = 0; k < 3; k++) begin
        addr = ($urandom & 32'hffff_ff00) | 32'(p << 6) | 32'(k << 4);
        id   = (p == 0) ? IC_ID : (p == 1) ? DC_ID : UC_ID;
        expect_q.push_back({id, addr});
        if (p == 0) i_q.push_back(addr);
        if (p == 1) d_q.push_back(addr);
        if (p == 2) u_q.push_back(addr);
      end
    end
    i_buffered = 1'b0;
    held       = 1'b0;
    held_ar    = '0;
    grant_wait = '0;
    last_port  = -1;
    cycles     = 0;
    @(posedge clk_i);
    icache_miss_valid_i <= 1'b1;
    icache_miss_i       <= {i_q[0], 1'b0, IC_ID};
    dcache_miss_valid_i <= 1'b1;
    dcache_miss_i       <= make_read_req(d_q[0], DC_ID, 1'b1);
    uc_read_valid_i     <= 1'b1;
    uc_read_i           <= make_read_req(u_q[0], UC_ID, 1'b0);
    ar_ready_i          <= 1'($urandom % 2);
    while (expect_q.size() > 0 && cycles < ARB_LIMIT) begin
      @(negedge clk_i);
      cycles++;
      // The I$ competes only while its buffer holds a miss
      waiting = {uc_read_valid_i, dcache_miss_valid_i, i_buffered};
      if (held && (ar_valid_o !== 1'b1 || ar_o !== held_ar)) value_error("ar_o", held_ar, ar_o);
      if (!held && ar_valid_o) grant_wait = waiting;
      if (ar_valid_o && ar_ready_i) begin
        port = port_of_id(ar_o.id);
        if (port == last_port && (grant_wait & ~(3'b001 << port)) != 3'b000) begin
          note_failure("A requester was served twice in a row while another waited");
        end
        last_port = port;
        if (ar_o.cache !== ((port == 2) ? EXP_DEVICE : EXP_CACHED)) begin
          value_error("ar_o.cache", (port == 2) ? EXP_DEVICE : EXP_CACHED, ar_o.cache);
        end
        hit = -1;
        foreach (expect_q[j]) begin
          if (expect_q[j] === {ar_o.id, ar_o.addr}) hit = j;
        end
        if (hit < 0) begin
          note_failure("AR carried a request that was not pending");
        end else begin
          expect_q.delete(hit);
        end
        if (port == 0) i_buffered = 1'b0;
      end
      held    = ar_valid_o && !ar_ready_i;
      held_ar = ar_o;
      i_go    = icache_miss_valid_i && icache_miss_ready_o;
      d_go    = dcache_miss_valid_i && dcache_miss_ready_o;
      u_go    = uc_read_valid_i && uc_read_ready_o;
      // A D$ port sees ready only in the cycle its request leaves on AR
      d_exp   = ar_valid_o && ar_ready_i && (ar_o.id == DC_ID);
      u_exp   = ar_valid_o && ar_ready_i && (ar_o.id == UC_ID);
      if (dcache_miss_valid_i && dcache_miss_ready_o !== d_exp) begin
        value_error("dcache_miss_ready_o", d_exp, dcache_miss_ready_o);
      end
      if (uc_read_valid_i && uc_read_ready_o !== u_exp) begin
        value_error("uc_read_ready_o", u_exp, uc_read_ready_o);
      end
      @(posedge clk_i);
      if (i_go) begin
        addr       = i_q.pop_front();
        i_buffered = 1'b1;
        if (i_q.size() > 0) icache_miss_i <= {i_q[0], 1'b0, IC_ID};
        else icache_miss_valid_i <= 1'b0;
      end
      if (d_go) begin
        addr = d_q.pop_front();
        if (d_q.size() > 0) dcache_miss_i <= make_read_req(d_q[0], DC_ID, 1'b1);
        else dcache_miss_valid_i <= 1'b0;
      end
      if (u_go) begin
        addr = u_q.pop_front();
        if (u_q.size() > 0) uc_read_i <= make_read_req(u_q[0], UC_ID, 1'b0);
        else uc_read_valid_i <= 1'b0;
      end
      ar_ready_i <= 1'($urandom % 2);
    end
    if (expect_q.size() > 0) note_failure("Not every request reached AR in time");
    icache_miss_valid_i <= 1'b0;
    dcache_miss_valid_i <= 1'b0;
    uc_read_valid_i     <= 1'b0;
    ar_ready_i          <= 1'b1;
  endtask

  initial begin
    void'($urandom(SEED));
    err_cnt                  = 0;
    tests_run                = 0;
    clk_i                    = 1'b0;
    reset_i                  = 1'b1;
    icache_miss_valid_i      = 1'b0;
    icache_miss_i            = '0;
    icache_id_i              = IC_ID;
    dcache_miss_valid_i      = 1'b0;
    dcache_miss_i            = '0;
    dcache_miss_resp_ready_i = 1'b0;
    uc_read_valid_i          = 1'b0;
    uc_read_i                = '0;
    uc_read_id_i             = UC_ID;
    uc_read_resp_ready_i     = 1'b0;
    ar_ready_i               = 1'b1;
    r_valid_i                = 1'b0;
    r_i                      = '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    reset_check();
    icache_cached_check();
    icache_uncached_check();
    routing_check();
    arbitration_check();
    repeat (2) @(posedge clk_i);
    $display("Tests run: %0d, errors: %0d", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
